//--- logic/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

  // One instruction word in R-format field order
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } instr_t;

  typedef logic [31:0] word_t;

  localparam word_t RESET_VECTOR = 32'hBFC0_0000;

  // Both memories hold 64 words, indexed by address bits 7..2
  localparam int MEM_ADDR_BITS = 6;

  localparam logic [4:0] REG_V0 = 5'd2;
  localparam logic [4:0] REG_RA = 5'd31;

  // Opcodes
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_J     = 6'h02;
  localparam logic [5:0] OP_JAL   = 6'h03;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_BNE   = 6'h05;
  localparam logic [5:0] OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_SLTI  = 6'h0A;
  localparam logic [5:0] OP_ANDI  = 6'h0C;
  localparam logic [5:0] OP_ORI   = 6'h0D;
  localparam logic [5:0] OP_XORI  = 6'h0E;
  localparam logic [5:0] OP_LUI   = 6'h0F;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2B;

  // Function codes for OP_RTYPE
  localparam logic [5:0] FUNCT_SLL  = 6'h00;
  localparam logic [5:0] FUNCT_SRL  = 6'h02;
  localparam logic [5:0] FUNCT_JR   = 6'h08;
  localparam logic [5:0] FUNCT_ADDU = 6'h21;
  localparam logic [5:0] FUNCT_SUBU = 6'h23;
  localparam logic [5:0] FUNCT_AND  = 6'h24;
  localparam logic [5:0] FUNCT_OR   = 6'h25;
  localparam logic [5:0] FUNCT_XOR  = 6'h26;
  localparam logic [5:0] FUNCT_SLT  = 6'h2A;

  // I-format immediate overlays rd, shamt and funct
  function automatic logic [15:0] instr_imm(instr_t i);
    return {i.rd, i.shamt, i.funct};
  endfunction

  // J-format target covers everything below the opcode
  function automatic logic [25:0] instr_target(instr_t i);
    return {i.rs, i.rt, i.rd, i.shamt, i.funct};
  endfunction

endpackage

`default_nettype wire

//--- logic/mips_ctrl_pkg.sv
`default_nettype none

package mips_ctrl_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_LUI
  } alu_op_e;

  // Source of register write data
  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_LINK
  } wb_sel_e;

  // Destination register field
  typedef enum logic [1:0] {
    DST_RT,
    DST_RD,
    DST_RA
  } dst_sel_e;

  typedef struct packed {
    logic     reg_write;
    dst_sel_e dst_sel;
    alu_op_e  alu_op;
    logic     alu_src_imm;
    logic     imm_zero_ext;
    logic     mem_read;
    logic     mem_write;
    wb_sel_e  wb_sel;
    logic     branch_eq;
    logic     branch_ne;
    logic     jump;
    logic     jump_reg;
  } ctrl_t;

endpackage

`default_nettype wire

//--- logic/mips_word_ram.sv
`timescale 1ns/1ps
`default_nettype none

module mips_word_ram
  import mips_isa_pkg::*;
#(
  parameter type payload_t = word_t
)
(
  input  logic                     clk,
  input  logic                     write_en,
  input  logic [MEM_ADDR_BITS-1:0] write_index,
  input  logic [MEM_ADDR_BITS-1:0] read_index,
  input  payload_t                 write_data,
  output payload_t                 read_data
);

  // Contents survive reset so a loaded program stays in place
  payload_t mem [1 << MEM_ADDR_BITS];

  always_ff @(posedge clk)
  begin
    if (write_en)
    begin
      mem[write_index] <= write_data;
    end
  end

  assign read_data = mem[read_index];

endmodule

`default_nettype wire

//--- logic/mips_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module mips_regfile
  import mips_isa_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       write_en,
  input  logic [4:0] read_reg1,
  input  logic [4:0] read_reg2,
  input  logic [4:0] write_reg,
  input  word_t      write_data,
  output word_t      read_data1,
  output word_t      read_data2,
  output word_t      register_v0
);

  word_t regs [32];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (write_en && (write_reg != 5'd0))
    begin
      regs[write_reg] <= write_data;
    end
  end

  // $zero is never written, so it reads back as 0
  assign read_data1  = regs[read_reg1];
  assign read_data2  = regs[read_reg2];
  assign register_v0 = regs[REG_V0];

endmodule

`default_nettype wire

//--- logic/mips_alu.sv
`timescale 1ns/1ps
`default_nettype none

module mips_alu
  import mips_isa_pkg::*, mips_ctrl_pkg::*;
(
  input  alu_op_e    op,
  input  word_t      a,
  input  word_t      b,
  input  logic [4:0] shamt,
  input  logic       branch_eq,
  input  logic       branch_ne,
  output word_t      result,
  output logic       take_branch
);

  logic operands_equal;

  always_comb
  begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      // Signed compare, result is 0 or 1
      ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};
      // Shifts act on rt, which arrives on b
      ALU_SLL: result = b << shamt;
      ALU_SRL: result = b >> shamt;
      ALU_LUI: result = {b[15:0], 16'h0000};
      default: result = '0;
    endcase
  end

  // Branches compare rs against rt
  assign operands_equal = (a == b);
  assign take_branch    = (branch_eq && operands_equal) || (branch_ne && !operands_equal);

endmodule

`default_nettype wire

//--- logic/mips_control.sv
`timescale 1ns/1ps
`default_nettype none

module mips_control
  import mips_isa_pkg::*, mips_ctrl_pkg::*;
(
  input  instr_t instr,
  output ctrl_t  ctrl
);

  always_comb
  begin
    // Anything not decoded below stays a NOP
    ctrl = '0;
    case (instr.opcode)
      OP_RTYPE:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.dst_sel   = DST_RD;
        ctrl.wb_sel    = WB_ALU;
        case (instr.funct)
          FUNCT_ADDU: ctrl.alu_op = ALU_ADD;
          FUNCT_SUBU: ctrl.alu_op = ALU_SUB;
          FUNCT_AND:  ctrl.alu_op = ALU_AND;
          FUNCT_OR:   ctrl.alu_op = ALU_OR;
          FUNCT_XOR:  ctrl.alu_op = ALU_XOR;
          FUNCT_SLT:  ctrl.alu_op = ALU_SLT;
          FUNCT_SLL:  ctrl.alu_op = ALU_SLL;
          FUNCT_SRL:  ctrl.alu_op = ALU_SRL;
          FUNCT_JR:
          begin
            ctrl.reg_write = 1'b0;
            ctrl.jump_reg  = 1'b1;
          end
          default:    ctrl.reg_write = 1'b0;
        endcase
      end
      OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
      begin
        ctrl.reg_write   = 1'b1;
        ctrl.dst_sel     = DST_RT;
        ctrl.alu_src_imm = 1'b1;
        ctrl.wb_sel      = WB_ALU;
        // Logical immediates are zero extended
        ctrl.imm_zero_ext = (instr.opcode == OP_ANDI) || (instr.opcode == OP_ORI) ||
                            (instr.opcode == OP_XORI);
        case (instr.opcode)
          OP_SLTI: ctrl.alu_op = ALU_SLT;
          OP_ANDI: ctrl.alu_op = ALU_AND;
          OP_ORI:  ctrl.alu_op = ALU_OR;
          OP_XORI: ctrl.alu_op = ALU_XOR;
          OP_LUI:  ctrl.alu_op = ALU_LUI;
          default: ctrl.alu_op = ALU_ADD;
        endcase
      end
      OP_LW:
      begin
        ctrl.reg_write   = 1'b1;
        ctrl.dst_sel     = DST_RT;
        ctrl.alu_op      = ALU_ADD;
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.wb_sel      = WB_MEM;
      end
      OP_SW:
      begin
        ctrl.alu_op      = ALU_ADD;
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
      end
      OP_BEQ: ctrl.branch_eq = 1'b1;
      OP_BNE: ctrl.branch_ne = 1'b1;
      OP_J:   ctrl.jump = 1'b1;
      OP_JAL:
      begin
        ctrl.jump      = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.dst_sel   = DST_RA;
        ctrl.wb_sel    = WB_LINK;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/mips_cpu_harvard.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_harvard
  import mips_isa_pkg::*, mips_ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   clk_enable,
  output logic   active,
  output word_t  register_v0,
  output word_t  instr_address,
  input  instr_t instr_readdata,
  output word_t  data_address,
  output word_t  data_writedata,
  output logic   data_write,
  output logic   data_read,
  input  word_t  data_readdata
);

  ctrl_t       ctrl;
  word_t       pc;
  word_t       pc_plus4;
  word_t       pc_plus8;
  word_t       next_pc;
  word_t       pending_target;
  logic        pending_valid;
  logic        advance;
  logic [15:0] imm;
  word_t       imm_ext;
  word_t       imm_sext;
  word_t       branch_target;
  word_t       jump_target;
  word_t       redirect_target;
  logic        redirect;
  logic        take_branch;
  word_t       rs_data;
  word_t       rt_data;
  word_t       alu_b;
  word_t       alu_result;
  logic [4:0]  write_reg;
  word_t       write_data;

  // One instruction retires per enabled edge while running out of reset
  assign advance = clk_enable && active && !reset;

  mips_control control_i (
    .instr (instr_readdata),
    .ctrl  (ctrl)
  );

  mips_regfile regfile_i (
    .clk         (clk),
    .reset       (reset),
    .write_en    (ctrl.reg_write && advance),
    .read_reg1   (instr_readdata.rs),
    .read_reg2   (instr_readdata.rt),
    .write_reg   (write_reg),
    .write_data  (write_data),
    .read_data1  (rs_data),
    .read_data2  (rt_data),
    .register_v0 (register_v0)
  );

  // Immediate extension
  assign imm      = instr_imm(instr_readdata);
  assign imm_sext = {{16{imm[15]}}, imm};
  assign imm_ext  = ctrl.imm_zero_ext ? {16'h0000, imm} : imm_sext;
  assign alu_b    = ctrl.alu_src_imm ? imm_ext : rt_data;

  mips_alu alu_i (
    .op          (ctrl.alu_op),
    .a           (rs_data),
    .b           (alu_b),
    .shamt       (instr_readdata.shamt),
    .branch_eq   (ctrl.branch_eq),
    .branch_ne   (ctrl.branch_ne),
    .result      (alu_result),
    .take_branch (take_branch)
  );

  assign pc_plus4 = pc + 32'd4;
  assign pc_plus8 = pc + 32'd8;

  // Control transfer targets
  assign branch_target = pc_plus4 + {imm_sext[29:0], 2'b00};
  assign jump_target   = {pc_plus4[31:28], instr_target(instr_readdata), 2'b00};
  assign redirect      = take_branch || ctrl.jump || ctrl.jump_reg;

  always_comb
  begin
    if (ctrl.jump_reg)
      redirect_target = rs_data;
    else if (ctrl.jump)
      redirect_target = jump_target;
    else
      redirect_target = branch_target;
  end

  // Delay slot runs first, the held target follows
  assign next_pc = pending_valid ? pending_target : pc_plus4;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pc             <= RESET_VECTOR;
      pending_valid  <= 1'b0;
      pending_target <= '0;
      active         <= 1'b1;
    end
    else if (advance)
    begin
      pc             <= next_pc;
      pending_valid  <= redirect;
      pending_target <= redirect_target;
      // Jump to 0 halts
      if (next_pc == '0)
        active <= 1'b0;
    end
  end

  // Writeback register and data
  always_comb
  begin
    case (ctrl.dst_sel)
      DST_RD:  write_reg = instr_readdata.rd;
      DST_RA:  write_reg = REG_RA;
      default: write_reg = instr_readdata.rt;
    endcase
  end

  always_comb
  begin
    case (ctrl.wb_sel)
      WB_MEM:  write_data = data_readdata;
      WB_LINK: write_data = pc_plus8;
      default: write_data = alu_result;
    endcase
  end

  assign instr_address  = pc;
  assign data_address   = alu_result;
  assign data_writedata = rt_data;
  assign data_write     = ctrl.mem_write && advance;
  assign data_read      = ctrl.mem_read && active;

endmodule

`default_nettype wire

//--- logic/mips_system.sv
`timescale 1ns/1ps
`default_nettype none

module mips_system
  import mips_isa_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     clk_enable,
  input  logic                     prog_write,
  input  logic [MEM_ADDR_BITS-1:0] prog_address,
  input  instr_t                   prog_data,
  output logic                     active,
  output word_t                    register_v0
);

  word_t  instr_address;
  instr_t instr_readdata;
  word_t  data_address;
  word_t  data_writedata;
  logic   data_write;
  logic   data_read;
  word_t  data_readdata;
  word_t  data_ram_q;

  mips_cpu_harvard cpu_i (
    .clk            (clk),
    .reset          (reset),
    .clk_enable     (clk_enable),
    .active         (active),
    .register_v0    (register_v0),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_writedata (data_writedata),
    .data_write     (data_write),
    .data_read      (data_read),
    .data_readdata  (data_readdata)
  );

  // Program loader is the only writer of instruction memory
  mips_word_ram #(.payload_t(instr_t)) instr_ram_i (
    .clk         (clk),
    .write_en    (prog_write),
    .write_index (prog_address),
    .read_index  (instr_address[MEM_ADDR_BITS+1:2]),
    .write_data  (prog_data),
    .read_data   (instr_readdata)
  );

  mips_word_ram #(.payload_t(word_t)) data_ram_i (
    .clk         (clk),
    .write_en    (data_write),
    .write_index (data_address[MEM_ADDR_BITS+1:2]),
    .read_index  (data_address[MEM_ADDR_BITS+1:2]),
    .write_data  (data_writedata),
    .read_data   (data_ram_q)
  );

  // Read data only valid for loads
  assign data_readdata = data_read ? data_ram_q : '0;

endmodule

`default_nettype wire

//--- verif/mips_system_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module mips_system_assertions
  import mips_isa_pkg::*;
(
  input logic  clk,
  input logic  reset,
  input logic  clk_enable,
  input logic  active,
  input logic  data_write,
  input word_t register_v0
);

  int unsigned failure_count = 0;

  // No stores in reset or once halted
  store_needs_active: assert property (@(posedge clk)
    data_write |-> (active && !reset))
  else
  begin
    $error("data_write high in reset or while the core is halted");
    failure_count++;
  end

  // A stalled edge leaves the register file alone
  stall_holds_v0: assert property (@(posedge clk) disable iff (reset)
    !clk_enable |=> $stable(register_v0))
  else
  begin
    $error("register_v0 changed across a stalled edge");
    failure_count++;
  end

  active_after_reset: assert property (@(posedge clk) $fell(reset) |-> active)
  else
  begin
    $error("core not active on the first cycle after reset");
    failure_count++;
  end

endmodule

bind mips_system mips_system_assertions assertions_i (
  .clk         (clk),
  .reset       (reset),
  .clk_enable  (clk_enable),
  .active      (active),
  .data_write  (data_write),
  .register_v0 (register_v0)
);

`default_nettype wire

//--- verif/mips_system_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips_system_tb
  import mips_isa_pkg::*;
();

  localparam int NUM_PROGRAMS  = 6;
  localparam int PROGRAM_WORDS = 12;
  localparam int HALT_TIMEOUT  = 2000;

  // Register numbers used by the programs
  localparam logic [4:0] ZERO = 5'd0;
  localparam logic [4:0] T0   = 5'd8;
  localparam logic [4:0] T1   = 5'd9;
  localparam logic [4:0] T2   = 5'd10;
  localparam logic [4:0] T3   = 5'd11;
  localparam logic [4:0] T4   = 5'd12;
  localparam logic [4:0] T5   = 5'd13;
  localparam logic [4:0] RA   = 5'd31;

  logic                     clk;
  logic                     reset;
  logic                     clk_enable;
  logic                     prog_write;
  logic [MEM_ADDR_BITS-1:0] prog_address;
  instr_t                   prog_data;
  logic                     active;
  word_t                    register_v0;

  instr_t program_table [NUM_PROGRAMS][PROGRAM_WORDS];
  word_t  expected_v0 [NUM_PROGRAMS];
  logic   random_enable [NUM_PROGRAMS];
  logic   stall_mode;
  integer seed = 27;
  int     fill_prog;
  int     fill_pos;

  mips_system mips_system_i (
    .clk          (clk),
    .reset        (reset),
    .clk_enable   (clk_enable),
    .prog_write   (prog_write),
    .prog_address (prog_address),
    .prog_data    (prog_data),
    .active       (active),
    .register_v0  (register_v0)
  );

  always #20 clk = ~clk;

  // Enable strobe, random per cycle in stall mode
  always @(posedge clk)
  begin
    if (stall_mode)
      clk_enable <= 1'($random(seed));
    else
      clk_enable <= 1'b1;
  end

  function automatic instr_t rtype_word(input logic [5:0] funct, input logic [4:0] rd,
                                        input logic [4:0] rs, input logic [4:0] rt,
                                        input logic [4:0] shamt);
    return instr_t'({OP_RTYPE, rs, rt, rd, shamt, funct});
  endfunction

  function automatic instr_t itype_word(input logic [5:0] op, input logic [4:0] rt,
                                        input logic [4:0] rs, input logic [15:0] imm);
    return instr_t'({op, rs, rt, imm});
  endfunction

  // Target field for a word index in the region of the reset vector
  function automatic instr_t jtype_word(input logic [5:0] op, input int index);
    return instr_t'({op, RESET_VECTOR[27:2] + 26'(index)});
  endfunction

  task automatic add_word(input instr_t w);
    program_table[fill_prog][fill_pos] = w;
    fill_pos++;
  endtask

  // JR $0 with a NOP in its delay slot
  task automatic add_halt();
    add_word(rtype_word(FUNCT_JR, ZERO, ZERO, ZERO, 5'd0));
    add_word('0);
  endtask

  task automatic close_program(input word_t expected, input logic stalls);
    expected_v0[fill_prog]   = expected;
    random_enable[fill_prog] = stalls;
    fill_prog++;
    fill_pos = 0;
  endtask

  task automatic arith_program();
    add_word(itype_word(OP_ORI, T0, ZERO, 16'h7FFF));
    add_word(itype_word(OP_LUI, T1, ZERO, 16'hFFFF));
    add_word(rtype_word(FUNCT_ADDU, T2, T1, T0, 5'd0));
    add_word(itype_word(OP_ADDIU, T2, T2, 16'h8002));
    add_word(rtype_word(FUNCT_SUBU, REG_V0, T0, T2, 5'd0));
    add_word(rtype_word(FUNCT_AND, T3, T2, REG_V0, 5'd0));
    add_word(rtype_word(FUNCT_OR, REG_V0, REG_V0, T1, 5'd0));
    add_word(rtype_word(FUNCT_XOR, REG_V0, REG_V0, T3, 5'd0));
    add_word(itype_word(OP_ANDI, REG_V0, REG_V0, 16'hF00F));
    add_word(itype_word(OP_XORI, REG_V0, REG_V0, 16'h8421));
    add_halt();
  endtask

  task automatic build_table();
    fill_prog = 0;
    fill_pos  = 0;
    for (int p = 0; p < NUM_PROGRAMS; p++)
    begin
      for (int k = 0; k < PROGRAM_WORDS; k++)
      begin
        program_table[p][k] = '0;
      end
    end
    // Wraparound sums, zero extended logical immediates
    arith_program();
    close_program(32'h0000_F42F, 1'b0);
    // Signed compares and logical shifts
    add_word(itype_word(OP_ADDIU, T0, ZERO, 16'hFFFB));
    add_word(itype_word(OP_ADDIU, T1, ZERO, 16'h0003));
    add_word(rtype_word(FUNCT_SLT, REG_V0, T0, T1, 5'd0));
    add_word(rtype_word(FUNCT_SLT, T3, T1, T0, 5'd0));
    add_word(itype_word(OP_SLTI, T4, T0, 16'h0001));
    add_word(rtype_word(FUNCT_SLL, T4, ZERO, T4, 5'd8));
    add_word(rtype_word(FUNCT_SRL, T5, ZERO, T0, 5'd28));
    add_word(rtype_word(FUNCT_ADDU, T3, T3, T5, 5'd0));
    add_word(rtype_word(FUNCT_ADDU, REG_V0, REG_V0, T3, 5'd0));
    add_word(rtype_word(FUNCT_ADDU, REG_V0, REG_V0, T4, 5'd0));
    add_halt();
    close_program(32'h0000_0110, 1'b1);
    // Stores and loads at word 2 and word 31
    add_word(itype_word(OP_ADDIU, T0, ZERO, 16'h1234));
    add_word(itype_word(OP_LUI, T1, ZERO, 16'hCAFE));
    add_word(itype_word(OP_ORI, T1, T1, 16'hBEEF));
    add_word(itype_word(OP_ADDIU, T2, ZERO, 16'h0040));
    add_word(itype_word(OP_SW, T0, ZERO, 16'h0008));
    add_word(itype_word(OP_SW, T1, T2, 16'h003C));
    add_word(itype_word(OP_LW, T3, T2, 16'h003C));
    add_word(itype_word(OP_LW, REG_V0, ZERO, 16'h0008));
    add_word(rtype_word(FUNCT_XOR, REG_V0, REG_V0, T3, 5'd0));
    add_halt();
    close_program(32'hCAFE_ACDB, 1'b1);
    // Taken BEQ and BNE skip one word each, untaken BNE falls through
    add_word(itype_word(OP_ADDIU, T0, ZERO, 16'h0005));
    add_word(itype_word(OP_BEQ, T0, T0, 16'h0002));
    add_word(itype_word(OP_ADDIU, REG_V0, ZERO, 16'h0001));
    add_word(itype_word(OP_ADDIU, REG_V0, REG_V0, 16'h0100));
    add_word(itype_word(OP_BNE, ZERO, T0, 16'h0002));
    add_word(itype_word(OP_ADDIU, REG_V0, REG_V0, 16'h0002));
    add_word(itype_word(OP_ADDIU, REG_V0, REG_V0, 16'h0200));
    add_word(itype_word(OP_BNE, T0, T0, 16'h0002));
    add_word(itype_word(OP_ADDIU, REG_V0, REG_V0, 16'h0004));
    add_word(itype_word(OP_ADDIU, REG_V0, REG_V0, 16'h0008));
    add_halt();
    close_program(32'h0000_000F, 1'b1);
    // Call to word 7, return lands on word 3 with $31 = BFC0000C
    add_word(itype_word(OP_ADDIU, REG_V0, ZERO, 16'h0001));
    add_word(jtype_word(OP_JAL, 7));
    add_word(rtype_word(FUNCT_SLL, REG_V0, ZERO, REG_V0, 5'd4));
    add_word(rtype_word(FUNCT_ADDU, REG_V0, REG_V0, RA, 5'd0));
    add_word(itype_word(OP_ADDIU, REG_V0, REG_V0, 16'h0003));
    add_halt();
    add_word(itype_word(OP_ADDIU, REG_V0, REG_V0, 16'h0002));
    add_word(rtype_word(FUNCT_JR, ZERO, RA, ZERO, 5'd0));
    add_word(rtype_word(FUNCT_SLL, REG_V0, ZERO, REG_V0, 5'd4));
    close_program(32'hBFC0_012F, 1'b1);
    // First program again under random stalls
    arith_program();
    close_program(32'h0000_F42F, 1'b1);
  endtask

  task automatic check_value(input string what, input word_t actual, input word_t expected);
    if (actual !== expected)
    begin
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      $display("Test failures found");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic load_program(input int p);
    @(posedge clk);
    reset      <= 1'b1;
    stall_mode <= random_enable[p];
    for (int k = 0; k < PROGRAM_WORDS; k++)
    begin
      @(posedge clk);
      prog_write   <= 1'b1;
      prog_address <= MEM_ADDR_BITS'(k);
      prog_data    <= program_table[p][k];
    end
    @(posedge clk);
    prog_write <= 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic wait_for_halt(input int p);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (active && (cycles < HALT_TIMEOUT))
    begin
      @(negedge clk);
      cycles++;
    end
    if (active)
    begin
      $display("CPU never halted in program %0d", p);
      $display("Test failures found");
      $fatal(1, "Halt timeout");
    end
  endtask

  initial
  begin
    clk          = 1'b0;
    reset        = 1'b1;
    clk_enable   = 1'b0;
    prog_write   = 1'b0;
    prog_address = '0;
    prog_data    = '0;
    stall_mode   = 1'b0;
    build_table();
    for (int p = 0; p < NUM_PROGRAMS; p++)
    begin
      load_program(p);
      wait_for_halt(p);
      check_value($sformatf("register_v0 after program %0d", p), register_v0, expected_v0[p]);
    end
    if (mips_system_i.assertions_i.failure_count == 0)
    begin
      $display("All tests passed!");
      $finish;
    end
    else
    begin
      $display("Test failures found");
      $fatal(1, "Assertion failures during run");
    end
  end

endmodule

`default_nettype wire

//--- src.f
logic/mips_isa_pkg.sv
logic/mips_ctrl_pkg.sv
logic/mips_word_ram.sv
logic/mips_regfile.sv
logic/mips_alu.sv
logic/mips_control.sv
logic/mips_cpu_harvard.sv
logic/mips_system.sv
verif/mips_system_assertions.sv
verif/mips_system_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = mips_system_tb
FILE_LIST = src.f
LOG       = sim.log
PASS_MSG  = All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
